// ==== ecc_memory.f ====
+incdir+common
common/ecc_pkg.sv
hamming/hamming_encoder.sv
hamming/hamming_corrector.sv
design/ecc_storage.sv
design/scrub_timer.sv
design/scrub_fsm.sv
design/ecc_memory_top.sv
dv/ecc_memory_tb.sv

// ==== Makefile ====
TOP := ecc_memory_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
	  -f ecc_memory.f -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

// ==== dv/ecc_memory_tb.sv ====
`timescale 1ns/10ps

`include "hamming_settings.svh"

module ecc_memory_tb import ecc_pkg::*; ();

  localparam int CLK_PERIOD     = 4;
  localparam int DEPTH          = `ECC_DEPTH;
  localparam int CODE_W         = `ECC_CODE_WIDTH;
  localparam int FIX_W          = `ECC_FIX_COUNT_WIDTH;
  localparam int TESTS          = 5;
  localparam int SCRUB_WINDOW   = `ECC_DEPTH * (`ECC_SCRUB_INTERVAL + 4);
  localparam int RANDOM_CYCLES  = 4000;
  localparam int TIMEOUT_CYCLES = TESTS * `ECC_DEPTH * `ECC_SCRUB_INTERVAL * 4;
  // Host operation codes
  localparam int OP_IDLE  = 0;
  localparam int OP_WRITE = 1;
  localparam int OP_READ  = 2;
  localparam int OP_BOTH  = 3;

  logic             clk;
  logic             rst;
  logic             wr_en;
  addr_t            wr_addr;
  data_t            wr_data;
  codeword_t        inject_mask;
  logic             rd_en;
  addr_t            rd_addr;
  logic             rd_valid;
  data_t            rd_data;
  logic             rd_error;
  err_pos_t         rd_err_pos;
  logic [FIX_W-1:0] scrub_fixes;

  // Reference model of data and 1-based flipped position per word
  // Zero flip means a clean word
  data_t       model_data [DEPTH];
  int          model_flip [DEPTH];
  int unsigned model_gen  [DEPTH];
  // Read issued last cycle and checked in this one
  logic        pend_valid;
  addr_t       pend_addr;
  data_t       pend_data;
  int          pend_flip;
  int unsigned pend_gen;
  integer      seed;
  string       cur_test;
  int          test_errors;
  int          checks;
  int          tests_passed;
  int          tests_failed;
  logic        allow_scrubbed;

  ecc_memory_top dut (
    .clk         ( clk         ),
    .rst         ( rst         ),
    .wr_en       ( wr_en       ),
    .wr_addr     ( wr_addr     ),
    .wr_data     ( wr_data     ),
    .inject_mask ( inject_mask ),
    .rd_en       ( rd_en       ),
    .rd_addr     ( rd_addr     ),
    .rd_valid    ( rd_valid    ),
    .rd_data     ( rd_data     ),
    .rd_error    ( rd_error    ),
    .rd_err_pos  ( rd_err_pos  ),
    .scrub_fixes ( scrub_fixes )
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic int rand_below(input int n);
    rand_below = int'(($random(seed) & 32'h7fff_ffff) % n);
  endfunction

  // Position 1..12 of one flipped codeword bit
  function automatic int random_flip();
    random_flip = rand_below(CODE_W) + 1;
  endfunction

  task automatic check_data(input string what, input data_t exp, input data_t act);
    checks++;
    if (act !== exp) begin
      test_errors++;
      $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      test_errors++;
      $display("FAIL %s %s: expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  task automatic check_pos(input string what, input err_pos_t exp, input err_pos_t act);
    checks++;
    if (act !== exp) begin
      test_errors++;
      $display("FAIL %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input logic [FIX_W-1:0] exp,
                             input logic [FIX_W-1:0] act);
    checks++;
    if (act !== exp) begin
      test_errors++;
      $display("FAIL %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic check_read_result();
    logic     exp_error;
    err_pos_t exp_pos;
    check_flag("rd_valid", pend_valid, rd_valid);
    if (pend_valid) begin
      exp_error = (pend_flip != 0);
      exp_pos   = err_pos_t'(pend_flip);
      // Scrubber may have repaired the word before the host got to it
      if (allow_scrubbed && exp_error && !rd_error && rd_err_pos == '0) begin
        exp_error = 1'b0;
        exp_pos   = '0;
        if (model_gen[pend_addr] == pend_gen) begin
          model_flip[pend_addr] = 0;
        end
      end
      check_data("rd_data", pend_data, rd_data);
      check_flag("rd_error", exp_error, rd_error);
      check_pos("rd_err_pos", exp_pos, rd_err_pos);
    end
  endtask

  // One clock of host traffic followed by the check of last cycle's read
  task automatic host_cycle(input int op, input addr_t addr, input data_t data, input int flip);
    @(posedge clk);
    #1;
    wr_en       = (op == OP_WRITE) || (op == OP_BOTH);
    rd_en       = (op == OP_READ) || (op == OP_BOTH);
    wr_addr     = addr;
    rd_addr     = addr;
    wr_data     = data;
    inject_mask = (flip == 0) ? '0 : (codeword_t'(1) << (flip - 1));
    if (wr_en) begin
      model_data[addr] = data;
      model_flip[addr] = flip;
      model_gen[addr]++;
    end
    @(negedge clk);
    check_read_result();
    // Write wins over a read in the same cycle
    pend_valid = (op == OP_READ);
    pend_addr  = addr;
    pend_data  = model_data[addr];
    pend_flip  = model_flip[addr];
    pend_gen   = model_gen[addr];
  endtask

  task automatic begin_test(input string name, input logic tolerant);
    cur_test       = name;
    test_errors    = 0;
    checks         = 0;
    allow_scrubbed = tolerant;
  endtask

  task automatic end_test();
    host_cycle(OP_IDLE, '0, '0, 0);
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %s: ok, %0d checks", cur_test, checks);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors in %0d checks", cur_test, test_errors, checks);
    end
  endtask

  task automatic run_scrubbing();
    int               order [DEPTH];
    int               k;
    int               j;
    int               tmp;
    logic [FIX_W-1:0] fixes_before;
    begin_test("scrubbing", 1'b0);
    // Clean every word first so only the new flips get repaired
    for (int a = 0; a < DEPTH; a++) begin
      host_cycle(OP_WRITE, addr_t'(a), data_t'(rand_below(256)), 0);
      order[a] = a;
    end
    for (int a = DEPTH - 1; a > 0; a--) begin
      j        = rand_below(a + 1);
      tmp      = order[a];
      order[a] = order[j];
      order[j] = tmp;
    end
    k = 1 + rand_below(DEPTH);
    for (int i = 0; i < k; i++) begin
      host_cycle(OP_WRITE, addr_t'(order[i]), data_t'(rand_below(256)), random_flip());
    end
    fixes_before = scrub_fixes;
    repeat (SCRUB_WINDOW) begin
      host_cycle(OP_IDLE, '0, '0, 0);
    end
    check_count("scrub_fixes", FIX_W'(int'(fixes_before) + k), scrub_fixes);
    // A full sweep leaves every word clean
    for (int a = 0; a < DEPTH; a++) begin
      model_flip[a] = 0;
    end
    for (int a = 0; a < DEPTH; a++) begin
      host_cycle(OP_READ, addr_t'(a), '0, 0);
    end
    end_test();
  endtask

  initial begin : main
    addr_t addr;
    data_t first;
    int    r;
    seed = 32'hb91f_0f27;
    rst = 1'b1;
    wr_en = 1'b0;
    rd_en = 1'b0;
    wr_addr = '0;
    rd_addr = '0;
    wr_data = '0;
    inject_mask = '0;
    pend_valid = 1'b0;
    tests_passed = 0;
    tests_failed = 0;
    for (int a = 0; a < DEPTH; a++) begin
      model_data[a] = '0;
      model_flip[a] = 0;
      model_gen[a]  = 0;
    end
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    begin_test("clean_round_trip", 1'b0);
    repeat (16) begin
      addr = addr_t'(rand_below(DEPTH));
      host_cycle(OP_WRITE, addr, data_t'(rand_below(256)), 0);
      host_cycle(OP_READ, addr, '0, 0);
    end
    end_test();

    begin_test("single_bit_correction", 1'b0);
    repeat (24) begin
      addr = addr_t'(rand_below(DEPTH));
      host_cycle(OP_WRITE, addr, data_t'(rand_below(256)), random_flip());
      host_cycle(OP_READ, addr, '0, 0);
    end
    end_test();

    begin_test("host_priority", 1'b0);
    repeat (8) begin
      addr  = addr_t'(rand_below(DEPTH));
      first = data_t'(rand_below(256));
      host_cycle(OP_WRITE, addr, first, 0);
      host_cycle(OP_BOTH, addr, first ^ data_t'(1 + rand_below(255)), 0);
      host_cycle(OP_IDLE, '0, '0, 0);
      host_cycle(OP_READ, addr, '0, 0);
    end
    end_test();

    run_scrubbing();

    // Stale write-backs under mixed traffic show up as wrong data
    begin_test("write_back_cancel", 1'b1);
    repeat (RANDOM_CYCLES) begin
      r    = rand_below(10);
      addr = addr_t'(rand_below(DEPTH));
      if (r < 4) begin
        host_cycle(OP_WRITE, addr, data_t'(rand_below(256)),
                   (rand_below(2) == 1) ? random_flip() : 0);
      end else if (r < 8) begin
        host_cycle(OP_READ, addr, '0, 0);
      end else begin
        host_cycle(OP_IDLE, '0, '0, 0);
      end
    end
    end_test();

    $display("summary: %0d tests, %0d ok, %0d with errors", TESTS, tests_passed, tests_failed);
    if (tests_failed == 0 && tests_passed == TESTS) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("timeout: tests still running after %0d clock cycles", TIMEOUT_CYCLES);
    $display("sim failed");
    $finish;
  end

endmodule

// ==== design/ecc_memory_top.sv ====
`timescale 1ns/10ps

`include "hamming_settings.svh"

module ecc_memory_top import ecc_pkg::*; (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           wr_en,
  input  addr_t                          wr_addr,
  input  data_t                          wr_data,
  input  codeword_t                      inject_mask,
  input  logic                           rd_en,
  input  addr_t                          rd_addr,
  output logic                           rd_valid,
  output data_t                          rd_data,
  output logic                           rd_error,
  output err_pos_t                       rd_err_pos,
  output logic [`ECC_FIX_COUNT_WIDTH-1:0] scrub_fixes
);

  codeword_t host_code;
  codeword_t corrected_code;
  codeword_t mem_rdata;
  codeword_t mem_wdata;
  codeword_t mem_mask;
  logic      mem_en;
  logic      mem_we;
  addr_t     mem_addr;
  logic      sel_scrub_data;
  logic      scrub_due;
  logic      scrub_start;
  addr_t     scrub_addr;

  hamming_encoder #(
    .DATA_WIDTH ( `ECC_DATA_WIDTH )
  ) encoder (
    .data ( wr_data   ),
    .code ( host_code )
  );

  // Scrub write-back stores the repaired word with no fault mask
  assign mem_wdata = sel_scrub_data ? corrected_code : host_code;
  assign mem_mask  = sel_scrub_data ? '0 : inject_mask;

  ecc_storage storage (
    .clk         ( clk       ),
    .rst         ( rst       ),
    .en          ( mem_en    ),
    .we          ( mem_we    ),
    .addr        ( mem_addr  ),
    .wdata       ( mem_wdata ),
    .inject_mask ( mem_mask  ),
    .rdata       ( mem_rdata )
  );

  // Corrector output serves host reads and scrub checks alike
  hamming_corrector #(
    .DATA_WIDTH ( `ECC_DATA_WIDTH )
  ) corrector (
    .code                     ( mem_rdata      ),
    .error                    ( rd_error       ),
    .corrected_data           ( rd_data        ),
    .corrected_error_position ( rd_err_pos     ),
    .corrected_code           ( corrected_code )
  );

  scrub_timer timer (
    .clk         ( clk         ),
    .rst         ( rst         ),
    .scrub_start ( scrub_start ),
    .scrub_due   ( scrub_due   ),
    .scrub_addr  ( scrub_addr  )
  );

  scrub_fsm fsm (
    .clk            ( clk            ),
    .rst            ( rst            ),
    .wr_en          ( wr_en          ),
    .rd_en          ( rd_en          ),
    .wr_addr        ( wr_addr        ),
    .rd_addr        ( rd_addr        ),
    .scrub_addr     ( scrub_addr     ),
    .scrub_due      ( scrub_due      ),
    .corr_error     ( rd_error       ),
    .scrub_start    ( scrub_start    ),
    .mem_en         ( mem_en         ),
    .mem_we         ( mem_we         ),
    .mem_addr       ( mem_addr       ),
    .sel_scrub_data ( sel_scrub_data ),
    .rd_valid       ( rd_valid       ),
    .scrub_fixes    ( scrub_fixes    )
  );

endmodule

// ==== design/scrub_fsm.sv ====
`timescale 1ns/10ps

`include "hamming_settings.svh"

module scrub_fsm import ecc_pkg::*; (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           wr_en,
  input  logic                           rd_en,
  input  addr_t                          wr_addr,
  input  addr_t                          rd_addr,
  input  addr_t                          scrub_addr,
  input  logic                           scrub_due,
  input  logic                           corr_error,
  output logic                           scrub_start,
  output logic                           mem_en,
  output logic                           mem_we,
  output addr_t                          mem_addr,
  output logic                           sel_scrub_data,
  output logic                           rd_valid,
  output logic [`ECC_FIX_COUNT_WIDTH-1:0] scrub_fixes
);

  scrub_state_t state;
  scrub_state_t state_next;
  logic         host_rd;
  logic         hit_scrub;
  logic         fix_done;

  // A write in the same cycle drops the read
  assign host_rd   = rd_en && !wr_en;
  // Host write to the word being scrubbed makes the repair stale
  assign hit_scrub = wr_en && (wr_addr == scrub_addr);

  always_comb begin : next_state
    state_next     = state;
    mem_en         = wr_en || rd_en;
    mem_we         = wr_en;
    mem_addr       = wr_en ? wr_addr : rd_addr;
    sel_scrub_data = 1'b0;
    scrub_start    = 1'b0;
    fix_done       = 1'b0;
    case (state)
      IDLE, READ: begin
        // Scrub read only slips into a free port cycle
        if (scrub_due || (state == READ)) begin
          if (!wr_en && !rd_en) begin
            mem_en     = 1'b1;
            mem_addr   = scrub_addr;
            state_next = CHECK;
          end else begin
            state_next = READ;
          end
        end
      end
      CHECK: begin
        if (hit_scrub || !corr_error) begin
          scrub_start = 1'b1;
          state_next  = IDLE;
        end else if (host_rd) begin
          // Host read replaces the storage output so the word is fetched again
          state_next = READ;
        end else begin
          state_next = WRITE;
        end
      end
      WRITE: begin
        if (hit_scrub) begin
          scrub_start = 1'b1;
          state_next  = IDLE;
        end else if (host_rd) begin
          state_next = READ;
        end else if (!wr_en) begin
          // Store the corrected codeword in a free cycle
          mem_en         = 1'b1;
          mem_we         = 1'b1;
          mem_addr       = scrub_addr;
          sel_scrub_data = 1'b1;
          fix_done       = 1'b1;
          scrub_start    = 1'b1;
          state_next     = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= IDLE;
      rd_valid    <= 1'b0;
      scrub_fixes <= '0;
    end else begin
      state    <= state_next;
      rd_valid <= host_rd;
      if (fix_done) begin
        scrub_fixes <= scrub_fixes + 1'b1;
      end
    end
  end

  // Write-back only stores a word that the corrector still flags
  assert property (@(posedge clk) disable iff (rst)
    sel_scrub_data |-> corr_error);

  // Write-back uses the checked word, so no read sits right before it
  assert property (@(posedge clk) disable iff (rst)
    sel_scrub_data |-> !$past(mem_en && !mem_we));

endmodule

// ==== design/scrub_timer.sv ====
`timescale 1ns/10ps

`include "hamming_settings.svh"

module scrub_timer import ecc_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  scrub_start,
  output logic  scrub_due,
  output addr_t scrub_addr
);

  localparam int CNT_WIDTH = $clog2(`ECC_SCRUB_INTERVAL + 1);

  logic [CNT_WIDTH-1:0] count;

  always_ff @(posedge clk) begin
    if (rst) begin
      count      <= '0;
      scrub_due  <= 1'b0;
      scrub_addr <= '0;
    end else if (scrub_start) begin
      // Step done, restart the wait and move to the next word
      count     <= '0;
      scrub_due <= 1'b0;
      if (scrub_addr == addr_t'(`ECC_DEPTH - 1)) begin
        scrub_addr <= '0;
      end else begin
        scrub_addr <= scrub_addr + 1'b1;
      end
    end else if (count == CNT_WIDTH'(`ECC_SCRUB_INTERVAL - 1)) begin
      // Interval elapsed, hold the request until it is taken
      scrub_due <= 1'b1;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

// ==== design/ecc_storage.sv ====
`timescale 1ns/10ps

`include "hamming_settings.svh"

module ecc_storage import ecc_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      en,
  input  logic      we,
  input  addr_t     addr,
  input  codeword_t wdata,
  input  codeword_t inject_mask,
  output codeword_t rdata
);

  // Codeword array, one entry per address
  codeword_t mem [`ECC_DEPTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      // Clear every entry; zero is a valid codeword
      for (int i = 0; i < `ECC_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (en && we) begin
      // Mask bits flip the stored codeword on purpose
      mem[addr] <= wdata ^ inject_mask;
    end
  end

  // Registered read port, updated only by read accesses
  always_ff @(posedge clk) begin
    if (rst) begin
      rdata <= '0;
    end else if (en && !we) begin
      rdata <= mem[addr];
    end
  end

endmodule

// ==== hamming/hamming_corrector.sv ====
`timescale 1ns/10ps

`include "hamming_settings.svh"

module hamming_corrector import ecc_pkg::*; #(
  parameter DATA_WIDTH = `ECC_DATA_WIDTH
) (
  input  codeword_t code,
  output logic      error,
  output data_t     corrected_data,
  output err_pos_t  corrected_error_position,
  output codeword_t corrected_code
);

  localparam int PARITY_WIDTH       = `GET_HAMMING_PARITY_WIDTH(DATA_WIDTH);
  localparam int BLOCK_WIDTH        = DATA_WIDTH + PARITY_WIDTH;
  localparam int PADDED_DATA_WIDTH  = `GET_HAMMING_DATA_WIDTH(PARITY_WIDTH);
  localparam int PADDED_BLOCK_WIDTH = PADDED_DATA_WIDTH + PARITY_WIDTH;

  logic [PADDED_BLOCK_WIDTH-1:0] block;
  logic [PADDED_BLOCK_WIDTH-1:0] corrected_block;
  logic [PADDED_DATA_WIDTH-1:0]  data_padded;
  logic [PARITY_WIDTH-1:0]       syndrome;
  logic                          in_range;

  // Zero-extend the stored word up to the full Hamming block
  always_comb begin : pad_block
    block = '0;
    block[BLOCK_WIDTH-1:0] = code;
  end

  // Syndrome is the XOR of the positions of all set bits
  always_comb begin : calc_syndrome
    syndrome = '0;
    for (int pos = 1; pos <= PADDED_BLOCK_WIDTH; pos++) begin
      if (block[pos-1]) begin
        syndrome = syndrome ^ PARITY_WIDTH'(pos);
      end
    end
  end

  assign error    = (syndrome != '0);
  // Positions past the codeword only come from multi-bit damage
  assign in_range = (int'(syndrome) <= BLOCK_WIDTH);

  always_comb begin : flip_bit
    corrected_block = block;
    if (error && in_range) begin
      corrected_block[int'(syndrome) - 1] = ~block[int'(syndrome) - 1];
    end
  end

  // Pull data back out of the non-parity positions, in order
  always_comb begin : extract_data
    int d;
    d = 0;
    data_padded = '0;
    for (int pos = 1; pos <= PADDED_BLOCK_WIDTH; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        data_padded[d] = corrected_block[pos-1];
        d = d + 1;
      end
    end
  end

  assign corrected_data           = data_padded[DATA_WIDTH-1:0];
  assign corrected_code           = corrected_block[BLOCK_WIDTH-1:0];
  assign corrected_error_position = in_range ? err_pos_t'(syndrome) : '0;

  // Only single flips reach the array, so the syndrome must point inside it
  always_comb begin : syndrome_range_check
    if (error) begin
      assert (int'(syndrome) <= `ECC_CODE_WIDTH)
        else $error("syndrome %0d points outside the codeword", syndrome);
    end
  end

endmodule

// ==== hamming/hamming_encoder.sv ====
`timescale 1ns/10ps

`include "hamming_settings.svh"

module hamming_encoder import ecc_pkg::*; #(
  parameter DATA_WIDTH = `ECC_DATA_WIDTH
) (
  input  data_t     data,
  output codeword_t code
);

  // Parity count and the padded message it implies
  localparam int PARITY_WIDTH       = `GET_HAMMING_PARITY_WIDTH(DATA_WIDTH);
  localparam int CODE_WIDTH         = DATA_WIDTH + PARITY_WIDTH;
  localparam int PADDED_DATA_WIDTH  = `GET_HAMMING_DATA_WIDTH(PARITY_WIDTH);
  localparam int PADDED_BLOCK_WIDTH = PADDED_DATA_WIDTH + PARITY_WIDTH;

  logic [PADDED_DATA_WIDTH-1:0]  data_padded;
  logic [PADDED_BLOCK_WIDTH-1:0] block;

  // Unused upper message bits are zero
  always_comb begin : pad_data
    data_padded = '0;
    data_padded[DATA_WIDTH-1:0] = data;
  end

  always_comb begin : build_block
    int d;
    d = 0;
    block = '0;
    // Data goes to every position that is not a power of two
    for (int pos = 1; pos <= PADDED_BLOCK_WIDTH; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        block[pos-1] = data_padded[d];
        d = d + 1;
      end
    end
    // Parity p covers every position with bit p set
    for (int p = 0; p < PARITY_WIDTH; p++) begin
      for (int pos = 1; pos <= PADDED_BLOCK_WIDTH; pos++) begin
        if ((((pos >> p) & 1) == 1) && (pos != (1 << p))) begin
          block[(1 << p) - 1] = block[(1 << p) - 1] ^ block[pos-1];
        end
      end
    end
  end

  // Padding positions sit above the codeword and are dropped
  assign code = block[CODE_WIDTH-1:0];

endmodule

// ==== common/ecc_pkg.sv ====
`include "hamming_settings.svh"

package ecc_pkg;

  // User data word as seen by the host
  typedef logic [`ECC_DATA_WIDTH-1:0] data_t;

  // Stored word, bit i holds Hamming position i+1
  typedef logic [`ECC_CODE_WIDTH-1:0] codeword_t;

  // Word address into the array
  typedef logic [`ECC_ADDR_WIDTH-1:0] addr_t;

  // 1-based position of the repaired bit
  // Zero when the word was clean
  typedef logic [`ECC_POS_WIDTH-1:0] err_pos_t;

  // Scrub sequencing states
  // IDLE   waiting for the timer, host served
  // READ   scrub read pending behind host traffic
  // CHECK  storage output holds the scrubbed word
  // WRITE  corrected word waiting for a free port cycle
  typedef enum logic [1:0] {
    IDLE,
    READ,
    CHECK,
    WRITE
  } scrub_state_t;

endpackage

// ==== common/hamming_settings.svh ====
`ifndef HAMMING_SETTINGS_SVH
`define HAMMING_SETTINGS_SVH

// Smallest parity count p with 2**p >= data + p + 1
`define GET_HAMMING_PARITY_WIDTH(dw) \
  (((dw) <= 1)  ? 2 : \
   ((dw) <= 4)  ? 3 : \
   ((dw) <= 11) ? 4 : \
   ((dw) <= 26) ? 5 : \
   ((dw) <= 57) ? 6 : 7)

// Full message length that a given parity count covers
`define GET_HAMMING_DATA_WIDTH(pw) ((1 << (pw)) - (pw) - 1)

// Word geometry
`define ECC_DATA_WIDTH      8
`define ECC_PARITY_WIDTH    `GET_HAMMING_PARITY_WIDTH(`ECC_DATA_WIDTH)
`define ECC_CODE_WIDTH      (`ECC_DATA_WIDTH + `ECC_PARITY_WIDTH)
`define ECC_DEPTH           16
`define ECC_ADDR_WIDTH      $clog2(`ECC_DEPTH)
`define ECC_POS_WIDTH       $clog2(`ECC_CODE_WIDTH + 1)

// Scrub pacing and repair counter size
`define ECC_SCRUB_INTERVAL  64
`define ECC_FIX_COUNT_WIDTH 16

`endif
